//--- design/sci_pkg.sv
package sci_pkg;

  // --------------------------------------------------
  // Serial line timing
  // --------------------------------------------------

  // Clocks per serial bit, kept short for simulation
  localparam int BAUD_DIV = 16;

  // Start bit + 8 data bits + stop bit
  localparam int FRAME_BITS = 10;

  // --------------------------------------------------
  // Message
  // --------------------------------------------------

  localparam int MSG_LEN = 8;  // Characters per message

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  typedef logic [7:0] char_t;          // One character on the line
  typedef logic [2:0] char_idx_t;      // Position inside the message

  // Sized from the divisor so other baud rates still fit
  typedef logic [$clog2(BAUD_DIV)-1:0] baud_cnt_t;

  // Shifts done within one frame
  typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;

  // Fixed text, first entry goes out first
  localparam char_t MSG_TEXT [MSG_LEN] = '{
    "H",
    "o",
    "l",
    "a",
    "!",
    ".",
    ".",
    "."
  };

endpackage

//--- design/baud_tick_gen.sv
`timescale 1ns/1ps

// Bit period timer for the transmitter
// Counts clocks while run is high, one tick per bit period
module baud_tick_gen (
  input  logic clk,
  input  logic rstn,
  input  logic run,   // High while a frame is on the line
  output logic tick   // One-cycle pulse at the end of each bit
);

  import sci_pkg::*;

  baud_cnt_t cnt;  // Position inside the current bit

  // --------------------------------------------------
  // Divider
  // --------------------------------------------------

  // Held at zero while stopped, so a new frame gets a full first bit
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;                                  // Stopped
    end else if (cnt == baud_cnt_t'(BAUD_DIV - 1)) begin
      cnt <= '0;                                  // Bit done, wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Final count of the period
  assign tick = (cnt == baud_cnt_t'(BAUD_DIV - 1));

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The transmitter only drops run right after a tick, when the
  // count has already wrapped, so no stray tick can follow
  a_no_tick_when_stopped : assert property (
    @(posedge clk) disable iff (!rstn)
    !run |-> !tick
  ) else $error("baud_tick_gen: tick while run is low");

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

// 8N1 serial transmitter, LSB first
// A character is taken in any cycle with start and ready both high
module uart_tx (
  input  logic          clk,
  input  logic          rstn,
  input  sci_pkg::char_t data,   // Character to send
  input  logic          start,  // Send request, held by the controller
  output logic          ready,  // High when idle and able to accept
  output logic          tx      // Serial line, idle high
);

  import sci_pkg::*;

  logic [FRAME_BITS-1:0] frame;    // Bits still to go out, LSB on the line
  bit_cnt_t              bit_cnt;  // Ticks seen in this frame
  logic                  accept;   // Character taken this cycle
  logic                  run;      // Timer enable
  logic                  tick;     // End of a bit period

  assign accept = start && ready;
  assign run    = !ready;  // Timer runs for the whole frame

  // --------------------------------------------------
  // Bit timer
  // --------------------------------------------------

  baud_tick_gen u_baud (
    .clk  (clk),
    .rstn (rstn),
    .run  (run),
    .tick (tick)
  );

  // --------------------------------------------------
  // Frame shift register
  // --------------------------------------------------

  // Loaded as stop, data, start so the start bit sits in bit 0
  // Ones are shifted in behind, so the line rests high after the stop bit
  always_ff @(posedge clk) begin
    if (!rstn) begin
      frame <= '1;                               // Line idle
    end else if (accept) begin
      frame <= {1'b1, data, 1'b0};
    end else if (tick) begin
      frame <= {1'b1, frame[FRAME_BITS-1:1]};    // Next bit
    end
  end

  assign tx = frame[0];

  // --------------------------------------------------
  // Bit counter and ready
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bit_cnt <= '0;
      ready   <= 1'b1;
    end else if (accept) begin
      bit_cnt <= '0;                             // New frame
      ready   <= 1'b0;
    end else if (tick) begin
      if (bit_cnt == bit_cnt_t'(FRAME_BITS - 1)) begin
        // Last cycle of the stop bit, idle from the next one
        bit_cnt <= '0;
        ready   <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Holds only if the frame register has fully drained by the time
  // ready comes back
  a_idle_line_high : assert property (
    @(posedge clk) disable iff (!rstn)
    ready |-> tx
  ) else $error("uart_tx: tx low while ready is high");

  // Character from the selector must be settled when taken
  a_data_known : assert property (
    @(posedge clk) disable iff (!rstn)
    accept |-> !$isunknown(data)
  ) else $error("uart_tx: unknown data accepted");

  // A frame takes exactly FRAME_BITS bit periods
  a_frame_length : assert property (
    @(posedge clk) disable iff (!rstn)
    accept |=> !ready [*FRAME_BITS * BAUD_DIV] ##1 ready
  ) else $error("uart_tx: frame length is wrong");

endmodule

//--- design/msg_char_sel.sv
`timescale 1ns/1ps

// Character selector
// Index counter into the message text plus the text lookup
module msg_char_sel (
  input  logic           clk,
  input  logic           rstn,
  input  logic           advance,  // Step to the next character
  output sci_pkg::char_t ch,       // Character at the current index
  output logic           last      // Current index is the final one
);

  import sci_pkg::*;

  char_idx_t idx;  // Current position in the message

  // --------------------------------------------------
  // Index counter
  // --------------------------------------------------

  // Three bits, so it wraps from the last character back to the first
  always_ff @(posedge clk) begin
    if (!rstn) begin
      idx <= '0;
    end else if (advance) begin
      idx <= idx + 1'b1;
    end
  end

  // --------------------------------------------------
  // Text lookup
  // --------------------------------------------------

  // Plain mux over the constant text
  always_comb begin
    ch = MSG_TEXT[idx];
  end

  // Lets the controller end the message without seeing the index
  assign last = (idx == char_idx_t'(MSG_LEN - 1));

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // The controller spends a single cycle in NEXT per character,
  // so a double step would skip a letter
  a_single_advance : assert property (
    @(posedge clk) disable iff (!rstn)
    advance |=> !advance
  ) else $error("msg_char_sel: advance high two cycles in a row");

endmodule

//--- design/msg_ctrl.sv
`timescale 1ns/1ps

// Message controller
// Hands characters to the transmitter one at a time and steps the index
module msg_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic transmit,  // Registered dtr
  input  logic ready,     // Transmitter idle
  input  logic last,      // Current character is the final one
  output logic start,     // Send request to the transmitter
  output logic advance    // Step the character index
);

  typedef enum logic [1:0] {
    IDLE,   // Waiting for transmit
    TXCAR,  // Offering a character
    NEXT,   // Stepping the index
    END     // Waiting out the final frame
  } ctrl_state_t;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------

  // transmit is only looked at in IDLE, so a message that has
  // started always runs through all of its characters
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (transmit) begin
          state_nxt = TXCAR;
        end
      end
      TXCAR: begin
        if (ready) begin
          state_nxt = NEXT;  // Character taken this cycle
        end
      end
      NEXT: begin
        state_nxt = last ? END : TXCAR;
      end
      END: begin
        if (ready) begin
          state_nxt = IDLE;  // Final stop bit done
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // Outputs from the state alone
  assign start   = (state == TXCAR);
  assign advance = (state == NEXT);

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_start_advance_excl : assert property (
    @(posedge clk) disable iff (!rstn)
    !(start && advance)
  ) else $error("msg_ctrl: start and advance high together");

endmodule

//--- design/sci_msg_top.sv
`timescale 1ns/1ps

// Serial message sender
// Sends the fixed text over tx for as long as dtr is held high
module sci_msg_top (
  input  logic clk,
  input  logic rstn,
  input  logic dtr,  // Host request, asynchronous
  output logic tx    // 8N1 serial output
);

  import sci_pkg::*;

  logic  transmit;  // dtr in the clock domain
  logic  start;     // Controller to transmitter
  logic  advance;   // Controller to selector
  logic  ready;     // Transmitter to controller
  logic  last;      // Selector to controller
  char_t ch;        // Selector to transmitter

  // --------------------------------------------------
  // dtr input register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      transmit <= 1'b0;
    end else begin
      transmit <= dtr;  // One cycle of latency
    end
  end

  // --------------------------------------------------
  // Control, character path and transmitter
  // --------------------------------------------------

  msg_ctrl u_ctrl (
    .clk      (clk),
    .rstn     (rstn),
    .transmit (transmit),
    .ready    (ready),
    .last     (last),
    .start    (start),
    .advance  (advance)
  );

  msg_char_sel u_sel (
    .clk     (clk),
    .rstn    (rstn),
    .advance (advance),
    .ch      (ch),
    .last    (last)
  );

  uart_tx u_tx (
    .clk   (clk),
    .rstn  (rstn),
    .data  (ch),
    .start (start),
    .ready (ready),
    .tx    (tx)
  );

endmodule

//--- sim/tb_sci_msg.sv
`timescale 1ns/1ps

module tb_sci_msg;

  import sci_pkg::*;

  // --------------------------------------------------
  // Test constants
  // --------------------------------------------------

  localparam int CLK_PERIOD   = 100;  // ns
  localparam int DRIVE_DELAY  = 10;   // Input skew after the rising edge
  localparam int RESET_CYCLES = 16;
  localparam int EPISODES     = 12;
  localparam int MAX_HIGH     = 2000;  // Longest dtr high, cycles
  localparam int MAX_LOW      = 400;   // Longest dtr low, cycles
  localparam int FRAME_CYCLES = FRAME_BITS * BAUD_DIV;
  localparam int MAX_GAP      = 3;     // Idle cycles allowed between frames
  localparam int MAX_RESTART  = 6;     // dtr rise to start bit
  localparam int WATCHDOG_CYCLES =
    EPISODES * (MAX_HIGH + MAX_LOW) + EPISODES * MSG_LEN * FRAME_CYCLES + 4000;

  logic clk;
  logic rstn;
  logic dtr;
  logic tx;

  integer seed;             // $random state
  int     value_errors;     // Wrong levels or characters
  int     protocol_errors;  // Missing or unexpected frames

  // Receiver model state
  logic  rx_busy;      // Frame in progress
  int    rx_cycle;     // Cycle inside the current frame
  char_t rx_byte;      // Data bits collected so far
  logic  mid_bit;      // Mid-period sample of the current bit
  int    rx_count;     // Characters received so far
  int    gap;          // Idle cycles since the last stop bit
  logic  must_follow;  // Another frame due within MAX_GAP cycles
  logic  quiet;        // Message over with dtr low, line must stay idle
  int    wait_start;   // Cycles since dtr was seen high at a boundary, -1 if unarmed
  int    dtr_low_run;  // Consecutive cycles with dtr low

  sci_msg_top dut (
    .clk  (clk),
    .rstn (rstn),
    .dtr  (dtr),
    .tx   (tx)
  );

  // --------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Covers all episodes plus every message they can trigger
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  // Level changes just after the edge, held for the given cycles
  task automatic hold_dtr(input logic level, input int cycles);
    @(posedge clk);
    #(DRIVE_DELAY);
    dtr = level;
    repeat (cycles - 1) @(posedge clk);
  endtask

  // --------------------------------------------------
  // Receiver model
  // --------------------------------------------------

  task automatic reset_model();
    rx_busy     = 1'b0;
    rx_cycle    = 0;
    rx_byte     = '0;
    mid_bit     = 1'b1;
    rx_count    = 0;
    gap         = FRAME_CYCLES;  // Far from any frame
    must_follow = 1'b0;
    quiet       = 1'b1;          // Nothing sent yet
    wait_start  = -1;
    dtr_low_run = 0;
  endtask

  // One sample inside a frame, bit periods at fixed offsets from the start edge
  task automatic frame_sample();
    int    bit_no;
    int    pos;
    char_t exp_ch;
    bit_no = rx_cycle / BAUD_DIV;
    pos    = rx_cycle % BAUD_DIV;
    exp_ch = MSG_TEXT[rx_count % MSG_LEN];  // Own index, wraps per message
    if (pos == BAUD_DIV / 2) begin
      mid_bit = tx;
      if (bit_no == 0) begin
        assert (tx === 1'b0) else begin
          value_errors++;
          $display("[ERROR] time %0t: tx start bit expected 0 got %b", $time, tx);
        end
      end else if (bit_no == FRAME_BITS - 1) begin
        assert (tx === 1'b1) else begin
          value_errors++;
          $display("[ERROR] time %0t: tx stop bit expected 1 got %b", $time, tx);
        end
      end else begin
        rx_byte[bit_no - 1] = tx;  // LSB first
      end
    end
    // Bit must not have moved by the last cycle of its period
    if (pos == BAUD_DIV - 1) begin
      assert (tx === mid_bit) else begin
        value_errors++;
        $display("[ERROR] time %0t: tx bit %0d end expected %b got %b",
                 $time, bit_no, mid_bit, tx);
      end
    end
    if (rx_cycle == FRAME_CYCLES - 1) begin
      assert (rx_byte === exp_ch) else begin
        value_errors++;
        $display("[ERROR] time %0t: tx character %0d expected 0x%h got 0x%h",
                 $time, rx_count, exp_ch, rx_byte);
      end
      rx_count++;
      rx_busy     = 1'b0;
      gap         = 0;
      must_follow = (rx_count % MSG_LEN != 0);  // Mid-message
    end
  endtask

  // Falling edge on an idle line
  task automatic start_detected();
    assert (!quiet) else begin
      protocol_errors++;
      $display("Time %0t: start bit while dtr was low after a finished message", $time);
    end
    quiet       = 1'b0;
    must_follow = 1'b0;
    wait_start  = -1;
    rx_busy     = 1'b1;
    rx_cycle    = 0;
    rx_byte     = '0;
    frame_sample();
  endtask

  // Idle-high cycle between frames
  task automatic idle_sample();
    logic boundary;
    boundary = (rx_count % MSG_LEN == 0);  // Between messages
    gap++;
    // dtr still high in the first idle cycle, so the text repeats at once
    if (gap == 1 && boundary && dtr === 1'b1) begin
      must_follow = 1'b1;
    end
    if (must_follow) begin
      assert (gap <= MAX_GAP) else begin
        protocol_errors++;
        $display("Time %0t: no start bit within %0d idle cycles of the last stop bit",
                 $time, MAX_GAP);
        must_follow = 1'b0;
      end
    end
    if (wait_start >= 0) begin
      wait_start++;
      assert (wait_start <= MAX_RESTART) else begin
        protocol_errors++;
        $display("Time %0t: no start bit within %0d cycles of dtr rising",
                 $time, MAX_RESTART);
        wait_start = -1;
      end
    end
    if (boundary && !must_follow && wait_start < 0) begin
      if (dtr === 1'b1) begin
        quiet      = 1'b0;
        wait_start = 0;  // New message expected
      end else if (dtr_low_run >= 3) begin
        quiet = 1'b1;
      end
    end
  endtask

  // Outputs sampled mid-cycle, away from both edges
  // The clock start at time zero is a falling edge before any reset edge
  always @(negedge clk) begin
    if ($time == 0) begin
      reset_model();
    end else if (!rstn) begin
      assert (tx === 1'b1) else begin
        value_errors++;
        $display("[ERROR] time %0t: tx in reset expected 1 got %b", $time, tx);
      end
      reset_model();
    end else begin
      dtr_low_run = (dtr === 1'b1) ? 0 : dtr_low_run + 1;
      if (rx_busy) begin
        rx_cycle++;
        frame_sample();
      end else if (tx === 1'b0) begin
        start_detected();
      end else begin
        assert (tx === 1'b1) else begin
          value_errors++;
          $display("[ERROR] time %0t: tx idle expected 1 got %b", $time, tx);
        end
        idle_sample();
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int hi_cycles;
    int lo_cycles;
    int ep;
    seed            = 32'h5f09;
    value_errors    = 0;
    protocol_errors = 0;
    rstn            = 1'b0;
    dtr             = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rstn = 1'b1;
    repeat (20) @(posedge clk);  // Idle line with dtr low

    // Random dtr episodes, some drop mid-message, some span several
    for (ep = 0; ep < EPISODES; ep++) begin
      hi_cycles = 1 + ({$random(seed)} % MAX_HIGH);
      lo_cycles = 1 + ({$random(seed)} % MAX_LOW);
      hold_dtr(1'b1, hi_cycles);
      hold_dtr(1'b0, lo_cycles);
    end

    // Last message drains, then the line is watched a while
    while (!(quiet && !rx_busy)) begin
      @(posedge clk);
    end
    repeat (200) @(posedge clk);

    assert (rx_count % MSG_LEN == 0 && !rx_busy) else begin
      protocol_errors++;
      $display("Characters did not arrive in complete messages, %0d received", rx_count);
    end
    assert (rx_count > 0) else begin
      protocol_errors++;
      $display("No character was received during the run");
    end

    $display("Errors: %0d value, %0d protocol, %0d characters received",
             value_errors, protocol_errors, rx_count);
    if (value_errors + protocol_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
design/sci_pkg.sv
design/baud_tick_gen.sv
design/uart_tx.sv
design/msg_char_sel.sv
design/msg_ctrl.sv
design/sci_msg_top.sv
sim/tb_sci_msg.sv
